/* hyper_ctrl_golden.txt */
# rw addr_space burst_type addr size chip_sel, then expected burst head_mask cs_o, all hex
# non-burst and register-space writes have no data phase, so their expected burst is 0
1 0 1 00001000 0010 0  0008 0 1
1 0 1 00001001 0010 1  0009 1 2
1 0 1 00002000 0007 0  0004 0 1
1 0 1 00000100 0001 1  0001 2 2
0 0 1 00003000 0020 0  0010 0 1
0 0 1 00003003 0008 0  0005 1 1
0 0 1 00003010 0005 1  0003 0 2
0 0 1 00003020 0001 1  0001 2 2
0 0 1 00003101 0003 0  0002 1 1
0 1 1 00000800 0002 0  0000 0 1
0 0 0 00001000 0002 1  0000 0 2
1 1 0 00000000 0002 0  0001 0 1
1 0 1 00004000 0004 2  0002 0 0
0 0 1 00005002 0040 1  0020 0 2
1 0 1 00006001 0041 0  0021 1 1
0 0 1 00007000 0002 0  0001 0 1
0 0 1 00007001 0002 1  0002 1 2
1 0 0 00008000 0006 1  0003 0 2
0 1 0 00000001 0002 1  0000 1 2
0 0 1 00009000 000a 3  0005 0 0

/* hyper_ctrl_top.f */
hyper_ctrl_pkg.sv
hyper_cfg_regs.sv
hyper_trans_fsm.sv
hyper_byte_mask.sv
hyper_ctrl_top.sv
tb_hyper_ctrl.sv

/* Makefile */
# Verilator build and run of the HyperBus sequencer testbench

OBJ_DIR := obj_dir
LOG     := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   show this list"
	@echo "  test   build with Verilator, run tb_hyper_ctrl and check $(LOG)"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --timescale 1ns/1ps -f hyper_ctrl_top.f \
		--top-module tb_hyper_ctrl -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/Vtb_hyper_ctrl | tee $(LOG)
	grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb_hyper_ctrl.sv */
// self-checking testbench for hyper_ctrl_top, run from the project root so the golden file is found
// one PHY, two chip selects; recovery is reprogrammed to REC_CYCLES before the requests run
`timescale 1ns/1ps
`default_nettype none

module tb_hyper_ctrl;

    localparam int unsigned TRANS_SIZE      = 16;
    localparam int unsigned NR_CS           = 2;
    localparam int          REC_CYCLES      = 3;
    localparam int          REG_WAIT_CYCLES = 5;  // register-write wait plus one

    // one golden line, all columns as read from the file
    typedef struct packed {
        logic [31:0] rw;
        logic [31:0] addr_space;
        logic [31:0] burst_type;
        logic [31:0] addr;
        logic [31:0] size;
        logic [31:0] chip_sel;
        logic [31:0] burst;
        logic [31:0] head;
        logic [31:0] cs;
    } vec_t;

    logic                          clk_i;
    logic                          rst_ni;
    hyper_ctrl_pkg::hyper_req_t    req_i;
    logic                          req_valid_i;
    logic                          req_ready_o;
    logic                          phy_valid_o;
    logic                          phy_ready_i;
    hyper_ctrl_pkg::hyper_req_t    phy_req_o;
    logic                          rx_valid_i;
    logic                          rx_ready_i;
    logic                          tx_valid_i;
    logic                          tx_ready_i;
    logic [7:0]                    paddr_i;
    logic                          psel_i;
    logic                          penable_i;
    logic                          pwrite_i;
    logic [31:0]                   pwdata_i;
    logic [31:0]                   prdata_o;
    logic                          pready_o;
    logic                          pslverr_o;
    logic [TRANS_SIZE-1:0]         burst_o;
    logic [TRANS_SIZE-1:0]         remained_o;
    logic [1:0]                    mask_o;
    logic [NR_CS-1:0]              cs_o;
    hyper_ctrl_pkg::hyper_timing_t timing_o;

    vec_t vec_q[$];
    int   seed = 32'h18808b2a;
    int   err_cnt;
    int   test_cnt;
    int   fail_tests;
    logic load_ok;

    hyper_ctrl_top #(
        .TRANS_SIZE ( TRANS_SIZE ),
        .NR_CS      ( NR_CS      )
    ) i_dut (.*);

    initial
    begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    task automatic check_val(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("mismatch at %0d ns: %s got %0h expected %0h", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        test_cnt++;
        if (err_cnt == errs_before)
            $display("test %0d %s ok", test_cnt, name);
        else
        begin
            fail_tests++;
            $display("test %0d %s had %0d errors", test_cnt, name, err_cnt - errs_before);
        end
    endtask

    task automatic load_vectors(output logic ok);
        int          fd;
        int          n;
        string       line;
        logic [31:0] f [9];
        vec_t        v;
        ok = 1'b0;
        fd = $fopen("hyper_ctrl_golden.txt", "r");
        if (fd == 0)
            $display("error: cannot open hyper_ctrl_golden.txt");
        else
        begin
            while (!$feof(fd))
            begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && line.getc(0) != "#") // skip the column notes
                begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
                                f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]);
                    if (n == 9)
                    begin
                        v.rw         = f[0];
                        v.addr_space = f[1];
                        v.burst_type = f[2];
                        v.addr       = f[3];
                        v.size       = f[4];
                        v.chip_sel   = f[5];
                        v.burst      = f[6];
                        v.head       = f[7];
                        v.cs         = f[8];
                        vec_q.push_back(v);
                    end
                end
            end
            $fclose(fd);
            ok = (vec_q.size() > 0);
            if (!ok)
                $display("error: no request vectors found in hyper_ctrl_golden.txt");
        end
    endtask

    // one APB transfer, setup then access until pready_o
    task automatic apb_access(input logic [7:0] addr, input logic wr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err);
        @(posedge clk_i);
        paddr_i   <= addr;
        pwrite_i  <= wr;
        pwdata_i  <= wdata;
        psel_i    <= 1'b1;
        penable_i <= 1'b0;
        @(posedge clk_i);
        penable_i <= 1'b1;
        @(negedge clk_i);
        while (!pready_o)
            @(negedge clk_i);
        rdata = prdata_o;
        err   = pslverr_o;
        @(posedge clk_i);
        psel_i    <= 1'b0;
        penable_i <= 1'b0;
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
        logic [31:0] rdata;
        logic        err;
        apb_access(addr, 1'b1, data, rdata, err);
        check_val("pslverr_o on write", 32'(err), 32'd0);
    endtask

    task automatic read_reg_check(input logic [7:0] addr, input logic [31:0] exp,
                                  input logic exp_err, input string what);
        logic [31:0] rdata;
        logic        err;
        apb_access(addr, 1'b0, '0, rdata, err);
        check_val(what, rdata, exp);
        check_val({what, " pslverr_o"}, 32'(err), 32'(exp_err));
    endtask

    ////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////

    task automatic check_regs();
        int errs_before;
        errs_before = err_cnt;
        @(negedge clk_i);
        check_val("req_ready_o after reset", 32'(req_ready_o), 32'd1);
        check_val("phy_valid_o after reset", 32'(phy_valid_o), 32'd0);
        check_val("cs_o after reset", 32'(cs_o), 32'd0);
        check_val("burst_o after reset", 32'(burst_o), 32'd0);
        check_val("remained_o after reset", 32'(remained_o), 32'd0);
        check_val("mask_o after reset", 32'(mask_o), 32'd0);
        read_reg_check(8'h00, 32'd6, 1'b0, "recovery reset value");
        read_reg_check(8'h04, 32'h26, 1'b0, "latency reset value");  // 6 cycles, additional on
        read_reg_check(8'h08, 32'h302, 1'b0, "delay reset value");   // tap 2, check 3
        write_reg(8'h00, 32'(REC_CYCLES));
        write_reg(8'h04, 32'h09);
        write_reg(8'h08, 32'h0a05);
        read_reg_check(8'h00, 32'(REC_CYCLES), 1'b0, "recovery readback");
        read_reg_check(8'h04, 32'h09, 1'b0, "latency readback");
        read_reg_check(8'h08, 32'h0a05, 1'b0, "delay readback");
        check_val("timing_o", 32'(timing_o), {19'd0, 5'd9, 1'b0, 3'd5, 4'd10});
        read_reg_check(8'h0c, 32'd0, 1'b1, "unmapped offset");
        report_test("APB registers", errs_before);
    endtask

    task automatic run_vector(input vec_t v);
        hyper_ctrl_pkg::hyper_req_t r;
        logic       reg_write;
        logic [1:0] tail_exp;
        int         beats;
        int         wait_cycles;
        int         delay;
        int         errs_before;
        string      name;
        errs_before = err_cnt;
        reg_write   = (v.rw[0] == 1'b0) && (v.addr_space[0] || !v.burst_type[0]);
        r            = '0;
        r.rw         = v.rw[0];
        r.addr_space = v.addr_space[0];
        r.burst_type = v.burst_type[0];
        r.addr       = v.addr;
        r.size       = v.size[15:0];
        r.chip_sel   = v.chip_sel[4:0];
        r.intreg     = 16'($random(seed));

        @(posedge clk_i);
        req_i       <= r;
        req_valid_i <= 1'b1;
        @(negedge clk_i);
        while (!req_ready_o)
            @(negedge clk_i);
        @(posedge clk_i);                            // accepted here
        req_valid_i <= 1'b0;
        @(negedge clk_i);
        check_val("phy_valid_o in setup", 32'(phy_valid_o), 32'd1);
        check_val("req_ready_o after accept", 32'(req_ready_o), 32'd0);
        check_val("burst_o", 32'(burst_o), v.burst);
        check_val("cs_o in setup", 32'(cs_o), v.cs);
        check_val("phy_req_o addr", phy_req_o.addr, v.addr);
        check_val("phy_req_o size", 32'(phy_req_o.size), 32'(r.size));
        check_val("phy_req_o chip_sel", 32'(phy_req_o.chip_sel), 32'(r.chip_sel));
        check_val("phy_req_o intreg", 32'(phy_req_o.intreg), 32'(r.intreg));
        check_val("phy_req_o type bits",
                  32'({phy_req_o.rw, phy_req_o.addr_space, phy_req_o.burst_type}),
                  32'({r.rw, r.addr_space, r.burst_type}));

        // PHY answers after a random delay
        delay = $random(seed) & 3;
        repeat (delay) @(posedge clk_i);
        @(posedge clk_i);
        phy_ready_i <= 1'b1;
        @(negedge clk_i);
        while (!(phy_valid_o && phy_ready_i))
            @(negedge clk_i);
        @(posedge clk_i);
        phy_ready_i <= 1'b0;
        @(negedge clk_i);
        check_val("phy_valid_o after handshake", 32'(phy_valid_o), 32'd0);
        check_val("cs_o while active", 32'(cs_o), v.cs);
        if (!reg_write && !v.rw[0])
            check_val("head mask", 32'(mask_o), v.head);

        if (!reg_write)
        begin
            beats = 0;
            while (beats < int'(v.burst))
            begin
                @(posedge clk_i);
                if (v.rw[0])
                begin
                    rx_valid_i <= ($random(seed) & 3) != 0;
                    rx_ready_i <= ($random(seed) & 3) != 0;
                end
                else
                begin
                    tx_valid_i <= ($random(seed) & 3) != 0;
                    tx_ready_i <= ($random(seed) & 3) != 0;
                end
                @(negedge clk_i);
                check_val("remained_o countdown", 32'(remained_o), v.burst - 32'(beats));
                if (v.rw[0] ? (rx_valid_i && rx_ready_i) : (tx_valid_i && tx_ready_i))
                    beats++;
            end
            @(posedge clk_i);                        // last beat taken here
            rx_valid_i <= 1'b0;
            rx_ready_i <= 1'b0;
            tx_valid_i <= 1'b0;
            tx_ready_i <= 1'b0;
            @(negedge clk_i);
            check_val("remained_o after last beat", 32'(remained_o), 32'd0);
            tail_exp = (v.addr[0] ^ v.size[0]) ? 2'b10 : 2'b00; // last beat sees remained 1
            if (!v.rw[0])
                check_val("tail mask", 32'(mask_o), 32'(tail_exp));
        end

        // cycles with the counters cleared, register wait and recovery only
        wait_cycles = 0;
        while (!req_ready_o)
        begin
            if (burst_o == '0)
            begin
                wait_cycles++;
                check_val("remained_o while waiting", 32'(remained_o), 32'd0);
            end
            @(negedge clk_i);
        end
        if (reg_write)
            check_val("register wait and recovery cycles", wait_cycles,
                      REG_WAIT_CYCLES + REC_CYCLES);
        else
            check_val("recovery cycles", wait_cycles, REC_CYCLES);
        check_val("burst_o back in idle", 32'(burst_o), 32'd0);
        check_val("cs_o back in idle", 32'(cs_o), 32'd0);
        if (reg_write)
            name = "register write";
        else if (v.rw[0])
            name = "read";
        else
            name = "write";
        report_test(name, errs_before);
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence and watchdog
    ////////////////////////////////////////////////////////////

    initial
    begin
        rst_ni      = 1'b0;
        req_i       = '0;
        req_valid_i = 1'b0;
        phy_ready_i = 1'b0;
        rx_valid_i  = 1'b0;
        rx_ready_i  = 1'b0;
        tx_valid_i  = 1'b0;
        tx_ready_i  = 1'b0;
        paddr_i     = '0;
        psel_i      = 1'b0;
        penable_i   = 1'b0;
        pwrite_i    = 1'b0;
        pwdata_i    = '0;
        err_cnt     = 0;
        test_cnt    = 0;
        fail_tests  = 0;
        load_vectors(load_ok);
        repeat (3) @(posedge clk_i);
        rst_ni <= 1'b1;
        if (load_ok)
        begin
            check_regs();
            foreach (vec_q[i])
                run_vector(vec_q[i]);
        end
        $display("tests run %0d, tests with errors %0d, mismatches %0d",
                 test_cnt, fail_tests, err_cnt);
        if (load_ok && err_cnt == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

    initial
    begin
        int limit;
        #1;                                          // vectors are loaded at time zero
        limit = vec_q.size() * 200 + 1000;
        repeat (limit) @(posedge clk_i);
        $display("timeout: the run did not finish within %0d clock cycles", limit);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* hyper_ctrl_top.sv */
// HyperBus sequencer with its APB timing block, one PHY
// timing_o goes straight to the PHY, the recovery count stays inside
`timescale 1ns/1ps
`default_nettype none

module hyper_ctrl_top #(
    parameter int unsigned TRANS_SIZE = hyper_ctrl_pkg::TRANS_SIZE_W,
    parameter int unsigned NR_CS      = hyper_ctrl_pkg::NR_CS_DEFAULT
) (
    input  wire logic                          clk_i,
    input  wire logic                          rst_ni,

    input  wire hyper_ctrl_pkg::hyper_req_t    req_i,
    input  wire logic                          req_valid_i,
    output logic                               req_ready_o,

    output logic                               phy_valid_o,
    input  wire logic                          phy_ready_i,
    output hyper_ctrl_pkg::hyper_req_t         phy_req_o,

    input  wire logic                          rx_valid_i,
    input  wire logic                          rx_ready_i,
    input  wire logic                          tx_valid_i,
    input  wire logic                          tx_ready_i,

    input  wire logic [7:0]                    paddr_i,
    input  wire logic                          psel_i,
    input  wire logic                          penable_i,
    input  wire logic                          pwrite_i,
    input  wire logic [31:0]                   pwdata_i,
    output logic      [31:0]                   prdata_o,
    output logic                               pready_o,
    output logic                               pslverr_o,

    output logic      [TRANS_SIZE-1:0]         burst_o,
    output logic      [TRANS_SIZE-1:0]         remained_o,
    output logic      [1:0]                    mask_o,
    output logic      [NR_CS-1:0]              cs_o,
    output hyper_ctrl_pkg::hyper_timing_t      timing_o
);

    logic [31:0]                  t_recovery;
    hyper_ctrl_pkg::hyper_state_e state;
    logic                         tx_beat;
    logic [TRANS_SIZE-1:0]        mask_size;

    assign mask_size = TRANS_SIZE'(phy_req_o.size);

    hyper_cfg_regs i_cfg_regs (
        .clk_i        ( clk_i       ),
        .rst_ni       ( rst_ni      ),
        .paddr_i      ( paddr_i     ),
        .psel_i       ( psel_i      ),
        .penable_i    ( penable_i   ),
        .pwrite_i     ( pwrite_i    ),
        .pwdata_i     ( pwdata_i    ),
        .prdata_o     ( prdata_o    ),
        .pready_o     ( pready_o    ),
        .pslverr_o    ( pslverr_o   ),
        .t_recovery_o ( t_recovery  ),
        .timing_o     ( timing_o    )
    );

    hyper_trans_fsm #(
        .TRANS_SIZE ( TRANS_SIZE ),
        .NR_CS      ( NR_CS      )
    ) i_trans_fsm (
        .clk_i        ( clk_i       ),
        .rst_ni       ( rst_ni      ),
        .req_i        ( req_i       ),
        .req_valid_i  ( req_valid_i ),
        .req_ready_o  ( req_ready_o ),
        .phy_valid_o  ( phy_valid_o ),
        .phy_ready_i  ( phy_ready_i ),
        .phy_req_o    ( phy_req_o   ),
        .rx_valid_i   ( rx_valid_i  ),
        .rx_ready_i   ( rx_ready_i  ),
        .tx_valid_i   ( tx_valid_i  ),
        .tx_ready_i   ( tx_ready_i  ),
        .t_recovery_i ( t_recovery  ),
        .state_o      ( state       ),
        .burst_o      ( burst_o     ),
        .remained_o   ( remained_o  ),
        .tx_beat_o    ( tx_beat     ),
        .cs_o         ( cs_o        )
    );

    hyper_byte_mask #(
        .TRANS_SIZE ( TRANS_SIZE )
    ) i_byte_mask (
        .clk_i        ( clk_i               ),
        .rst_ni       ( rst_ni              ),
        .state_i      ( state               ),
        .tx_beat_i    ( tx_beat             ),
        .addr_lsb_i   ( phy_req_o.addr[1:0] ),
        .size_i       ( mask_size           ),
        .remained_i   ( remained_o          ),
        .mask_o       ( mask_o              )
    );

endmodule

`default_nettype wire

/* hyper_byte_mask.sv */
// byte mask for the 16-bit DQ bus; bit 0 masks the first byte of a beat
`timescale 1ns/1ps
`default_nettype none

module hyper_byte_mask #(
    parameter int unsigned TRANS_SIZE = hyper_ctrl_pkg::TRANS_SIZE_W
) (
    input  wire logic                          clk_i,
    input  wire logic                          rst_ni,
    input  wire hyper_ctrl_pkg::hyper_state_e  state_i,
    input  wire logic                          tx_beat_i,
    input  wire logic [1:0]                    addr_lsb_i,
    input  wire logic [TRANS_SIZE-1:0]         size_i,
    input  wire logic [TRANS_SIZE-1:0]         remained_i,
    output logic      [1:0]                    mask_o
);

    logic [1:0] tail;      // end position of the transfer within a word
    logic [1:0] head_mask;
    logic [1:0] tail_mask;

    assign tail = addr_lsb_i + size_i[1:0];

    assign head_mask = addr_lsb_i[0]              ? 2'b01 :  // odd start, skip low byte
                       (size_i == TRANS_SIZE'(1)) ? 2'b10 :  // single byte
                                                    2'b00;

    // last beat ends mid-word
    assign tail_mask = ((remained_i <= TRANS_SIZE'(2)) && tail[0]) ? 2'b10 : 2'b00;

    always_ff @(posedge clk_i or negedge rst_ni)
    begin
        if (!rst_ni)
            mask_o <= 2'b00;
        else
        begin
            case (state_i)
                hyper_ctrl_pkg::IDLE:  mask_o <= 2'b00;
                hyper_ctrl_pkg::SETUP: mask_o <= head_mask;
                hyper_ctrl_pkg::WRITE_DATA:
                begin
                    if (tx_beat_i)
                        mask_o <= tail_mask;
                end
                default: ; // hold
            endcase
        end
    end

endmodule

`default_nettype wire

/* hyper_trans_fsm.sv */
// one request in flight; a new request is taken only after the recovery wait
// register-space writes and non-burst writes skip the data phase
`timescale 1ns/1ps
`default_nettype none

module hyper_trans_fsm #(
    parameter int unsigned TRANS_SIZE = hyper_ctrl_pkg::TRANS_SIZE_W,
    parameter int unsigned NR_CS      = hyper_ctrl_pkg::NR_CS_DEFAULT
) (
    input  wire logic                        clk_i,
    input  wire logic                        rst_ni,

    input  wire hyper_ctrl_pkg::hyper_req_t  req_i,
    input  wire logic                        req_valid_i,
    output logic                             req_ready_o,

    output logic                             phy_valid_o,
    input  wire logic                        phy_ready_i,
    output hyper_ctrl_pkg::hyper_req_t       phy_req_o,

    input  wire logic                        rx_valid_i,
    input  wire logic                        rx_ready_i,
    input  wire logic                        tx_valid_i,
    input  wire logic                        tx_ready_i,

    input  wire logic [31:0]                 t_recovery_i,
    output hyper_ctrl_pkg::hyper_state_e     state_o,
    output logic      [TRANS_SIZE-1:0]       burst_o,
    output logic      [TRANS_SIZE-1:0]       remained_o,
    output logic                             tx_beat_o,
    output logic      [NR_CS-1:0]            cs_o
);

    logic        accept;
    logic        rx_beat;
    logic        beat;
    logic [31:0] cnt_q;     // shared by the register wait and the recovery
    logic [31:0] rec_load;

    // writes without a data phase
    function automatic logic is_reg_write(input hyper_ctrl_pkg::hyper_req_t r);
        return ~r.rw & (r.addr_space | ~r.burst_type);
    endfunction

    // 16-bit beats, one extra when the transfer starts or ends on an odd byte
    function automatic logic [TRANS_SIZE-1:0] beat_count(input hyper_ctrl_pkg::hyper_req_t r);
        logic odd;
        odd = r.size[0] | r.addr[0];
        return TRANS_SIZE'(r.size >> 1) + TRANS_SIZE'(odd);
    endfunction

    assign accept    = req_ready_o & req_valid_i;
    assign rx_beat   = (state_o == hyper_ctrl_pkg::READ_DATA) & rx_valid_i & rx_ready_i;
    assign tx_beat_o = (state_o == hyper_ctrl_pkg::WRITE_DATA) & tx_valid_i & tx_ready_i;
    assign beat      = rx_beat | tx_beat_o;
    assign rec_load  = (t_recovery_i == '0) ? '0 : t_recovery_i - 32'd1; // at least one cycle

    // request payload, held until the next accept
    always_ff @(posedge clk_i)
    begin
        if (accept)
            phy_req_o <= req_i;
    end

    ////////////////////////////////////////////////////////////
    // sequencing
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_ni)
    begin
        if (!rst_ni)
        begin
            state_o     <= hyper_ctrl_pkg::IDLE;
            req_ready_o <= 1'b1;
            phy_valid_o <= 1'b0;
            burst_o     <= '0;
            remained_o  <= '0;
            cnt_q       <= '0;
        end
        else
        begin
            case (state_o)
                hyper_ctrl_pkg::IDLE:
                begin
                    if (accept)
                    begin
                        state_o     <= hyper_ctrl_pkg::SETUP;
                        req_ready_o <= 1'b0;
                        phy_valid_o <= 1'b1;
                        if (!is_reg_write(req_i))
                        begin
                            burst_o    <= beat_count(req_i);
                            remained_o <= beat_count(req_i);
                        end
                    end
                end
                hyper_ctrl_pkg::SETUP:
                begin
                    if (phy_ready_i) // phy_valid_o is high throughout setup
                    begin
                        phy_valid_o <= 1'b0;
                        if (is_reg_write(phy_req_o))
                        begin
                            state_o <= hyper_ctrl_pkg::REG_WAIT;
                            cnt_q   <= 32'(hyper_ctrl_pkg::T_REG_W);
                        end
                        else if (phy_req_o.rw)
                            state_o <= hyper_ctrl_pkg::READ_DATA;
                        else
                            state_o <= hyper_ctrl_pkg::WRITE_DATA;
                    end
                end
                hyper_ctrl_pkg::REG_WAIT:
                begin
                    if (cnt_q == '0)
                    begin
                        state_o <= hyper_ctrl_pkg::RECOVERY;
                        cnt_q   <= rec_load;
                    end
                    else
                        cnt_q <= cnt_q - 32'd1;
                end
                hyper_ctrl_pkg::WRITE_DATA,
                hyper_ctrl_pkg::READ_DATA:
                begin
                    if (remained_o == '0)
                    begin
                        state_o <= hyper_ctrl_pkg::RECOVERY;
                        burst_o <= '0;
                        cnt_q   <= rec_load;
                    end
                    else if (beat)
                        remained_o <= remained_o - TRANS_SIZE'(1); // stalls with the PHY
                end
                hyper_ctrl_pkg::RECOVERY:
                begin
                    if (cnt_q == '0)
                    begin
                        state_o     <= hyper_ctrl_pkg::IDLE;
                        req_ready_o <= 1'b1;
                    end
                    else
                        cnt_q <= cnt_q - 32'd1;
                end
                default: state_o <= hyper_ctrl_pkg::IDLE;
            endcase
        end
    end

    // one-hot chip select, quiet in idle
    always_comb
    begin
        cs_o = '0;
        if (state_o != hyper_ctrl_pkg::IDLE)
            for (int i = 0; i < NR_CS; i++)
                cs_o[i] = (phy_req_o.chip_sel == 5'(i));
    end

endmodule

`default_nettype wire

/* hyper_cfg_regs.sv */
// APB timing registers, no wait states; writes take effect on the access phase
// unmapped offsets read as zero and flag pslverr_o
`timescale 1ns/1ps
`default_nettype none

module hyper_cfg_regs (
    input  wire logic                  clk_i,
    input  wire logic                  rst_ni,

    input  wire logic [7:0]            paddr_i,
    input  wire logic                  psel_i,
    input  wire logic                  penable_i,
    input  wire logic                  pwrite_i,
    input  wire logic [31:0]           pwdata_i,
    output logic      [31:0]           prdata_o,
    output logic                       pready_o,
    output logic                       pslverr_o,

    output logic      [31:0]           t_recovery_o,
    output hyper_ctrl_pkg::hyper_timing_t timing_o
);

    localparam int unsigned DW = hyper_ctrl_pkg::DELAY_W;

    logic wr_en;
    logic addr_hit;

    assign wr_en    = psel_i & penable_i & pwrite_i; // access phase only
    assign pready_o = 1'b1;

    always_ff @(posedge clk_i or negedge rst_ni)
    begin
        if (!rst_ni)
        begin
            t_recovery_o                      <= hyper_ctrl_pkg::RST_RECOVERY;
            timing_o.t_latency_access         <= hyper_ctrl_pkg::RST_LATENCY;
            timing_o.en_latency_additional    <= hyper_ctrl_pkg::RST_ADD_LAT;
            timing_o.t_rwds_delay_line        <= hyper_ctrl_pkg::RST_DELAY;
            timing_o.t_variable_latency_check <= hyper_ctrl_pkg::RST_VLC;
        end
        else if (wr_en)
        begin
            case (paddr_i)
                hyper_ctrl_pkg::REG_RECOVERY: t_recovery_o <= pwdata_i;
                hyper_ctrl_pkg::REG_LATENCY:
                begin
                    timing_o.t_latency_access      <= pwdata_i[4:0];
                    timing_o.en_latency_additional <= pwdata_i[5];
                end
                hyper_ctrl_pkg::REG_DELAY:
                begin
                    timing_o.t_rwds_delay_line        <= pwdata_i[DW-1:0];
                    timing_o.t_variable_latency_check <= pwdata_i[11:8];
                end
                default: ; // ignored, error flagged below
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // read back
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        prdata_o = '0;
        addr_hit = 1'b1;
        case (paddr_i)
            hyper_ctrl_pkg::REG_RECOVERY: prdata_o = t_recovery_o;
            hyper_ctrl_pkg::REG_LATENCY:
            begin
                prdata_o[4:0] = timing_o.t_latency_access;
                prdata_o[5]   = timing_o.en_latency_additional;
            end
            hyper_ctrl_pkg::REG_DELAY:
            begin
                prdata_o[DW-1:0] = timing_o.t_rwds_delay_line;
                prdata_o[11:8]   = timing_o.t_variable_latency_check;
            end
            default: addr_hit = 1'b0;
        endcase
    end

    assign pslverr_o = psel_i & penable_i & ~addr_hit;

endmodule

`default_nettype wire

/* hyper_ctrl_pkg.sv */
// shared types and constants for the HyperBus sequencer, single PHY with a 16-bit data bus
// register offsets assume a byte-addressed APB window of 256 bytes
`default_nettype none

package hyper_ctrl_pkg;

    ////////////////////////////////////////////////////////////
    // widths
    ////////////////////////////////////////////////////////////

    localparam int unsigned TRANS_SIZE_W  = 16; // byte and beat counters
    localparam int unsigned ADDR_W        = 32;
    localparam int unsigned NR_CS_DEFAULT = 2;
    localparam int unsigned DELAY_W       = 3;  // RWDS delay-line tap
    localparam int unsigned T_REG_W       = 4;  // register-write wait in cycles

    // APB offsets
    localparam logic [7:0] REG_RECOVERY = 8'h00;
    localparam logic [7:0] REG_LATENCY  = 8'h04; // [4:0] access latency, [5] additional
    localparam logic [7:0] REG_DELAY    = 8'h08; // [2:0] delay tap, [11:8] variable latency check

    // timing values after reset
    localparam logic [31:0]        RST_RECOVERY = 32'd6;
    localparam logic [4:0]         RST_LATENCY  = 5'd6;
    localparam logic               RST_ADD_LAT  = 1'b1;
    localparam logic [DELAY_W-1:0] RST_DELAY    = DELAY_W'(2);
    localparam logic [3:0]         RST_VLC      = 4'd3;

    ////////////////////////////////////////////////////////////
    // types
    ////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        IDLE,
        SETUP,
        REG_WAIT,
        WRITE_DATA,
        READ_DATA,
        RECOVERY
    } hyper_state_e;

    typedef struct packed {
        logic                    rw;         // 1 = read
        logic                    addr_space; // 1 = register space
        logic                    burst_type;
        logic [ADDR_W-1:0]       addr;
        logic [TRANS_SIZE_W-1:0] size;       // in bytes
        logic [4:0]              chip_sel;
        logic [15:0]             intreg;     // register write data
    } hyper_req_t;

    typedef struct packed {
        logic [4:0]         t_latency_access;
        logic               en_latency_additional;
        logic [DELAY_W-1:0] t_rwds_delay_line;
        logic [3:0]         t_variable_latency_check;
    } hyper_timing_t;

endpackage

`default_nettype wire
